//--- hw/cpuDefs.sv
package cpuDefs;

	localparam int ADDR_WIDTH = 16;
	localparam logic [ADDR_WIDTH-1:0] RESET_ADDR = '0;
	localparam logic [ADDR_WIDTH-1:0] INSTR_STEP = ADDR_WIDTH'(2); // one 16-bit word.

	typedef logic [15:0] instrWord;

	typedef enum logic [1:0] {
		GROUP_SYSTEM = 2'd0,
		GROUP_LOAD_STORE = 2'd1,
		GROUP_JUMP = 2'd2,
		GROUP_ARITHMETIC_LOGIC = 2'd3
	} instrGroup;

	// field positions.
	localparam int GROUP_MSB = 15;
	localparam int GROUP_LSB = 14;
	localparam int OPCODE_MSB = 13;
	localparam int OPCODE_LSB = 10;
	localparam int ARGA_MSB = 9;
	localparam int ARGA_LSB = 8;
	localparam int ARGB_MSB = 7;
	localparam int ARGB_LSB = 5;
	localparam int MODE_MSB = 4;
	localparam int MODE_LSB = 3;
	localparam int FLAGS_MSB = 2;
	localparam int FLAGS_LSB = 0;

	// opcode bits with a fixed meaning inside a group.
	localparam int LDS_STORE_BIT = 13;
	localparam int LDS_BYTE_BIT = 12;
	localparam int JMP_INDIRECT_BIT = 13;
	localparam int JMP_OFFSET_MSB = 12;
	localparam int JMP_OFFSET_LSB = 11;
	localparam int JMP_CALL_BIT = 10;

	localparam logic [3:0] ALU_WRITEBACK_LIMIT = 4'd8; // opcodes below write a register.

	function automatic instrGroup groupOf(instrWord w);
		return instrGroup'(w[GROUP_MSB:GROUP_LSB]);
	endfunction

	function automatic logic [3:0] opcodeOf(instrWord w);
		return w[OPCODE_MSB:OPCODE_LSB];
	endfunction

	function automatic logic [1:0] argAOf(instrWord w);
		return w[ARGA_MSB:ARGA_LSB];
	endfunction

	function automatic logic [2:0] argBOf(instrWord w);
		return w[ARGB_MSB:ARGB_LSB];
	endfunction

	function automatic logic [1:0] modeOf(instrWord w);
		return w[MODE_MSB:MODE_LSB];
	endfunction

	function automatic logic [2:0] flagsOf(instrWord w);
		return w[FLAGS_MSB:FLAGS_LSB];
	endfunction

endpackage

//--- hw/ctrlDefs.sv
package ctrlDefs;

	typedef enum logic [3:0] {
		ALU_OP_MOV = 4'd0,
		ALU_OP_ADD = 4'd1
	} aluOpSel;

	typedef enum logic [2:0] {
		ALUA_SRC_REG_A = 3'd0
	} aluASrcSel;

	typedef enum logic [2:0] {
		ALUB_SRC_REG_B = 3'd0
	} aluBSrcSel;

	typedef enum logic [1:0] {
		ADDR_BUS_PC_A = 2'd0,
		ADDR_BUS_ALU_R = 2'd1,
		ADDR_BUS_REGB_DOUT = 2'd2
	} addrBusSel;

	typedef enum logic [1:0] {
		DATA_BUS_REGA_DOUT = 2'd0,
		DATA_BUS_ALU_R = 2'd1
	} dataBusSel;

	typedef enum logic [1:0] {
		PC_BASE_PC_A = 2'd0
	} pcBaseSel;

	typedef enum logic [1:0] {
		PC_OFFSET_2 = 2'd1
	} pcOffsetSel;

	// register sequences run by the datapath after the instruction.
	typedef enum logic [2:0] {
		REG_SEQ_NONE = 3'd0,
		REG_SEQ_WRITEBACK = 3'd1,
		REG_SEQ_MEMORY = 3'd2,
		REG_SEQ_LINK = 3'd3
	} regSeqSel;

	typedef enum logic [1:0] {
		REGA_ADDR_ARGA = 2'd0
	} regAAddrSel;

	typedef enum logic [1:0] {
		REGA_DIN_DIN = 2'd0,
		REGA_DIN_ALU_R = 2'd1
	} regADinSel;

	typedef enum logic [2:0] {
		REGB_ADDR_ARGB = 3'd0
	} regBAddrSel;

	typedef enum logic {BYTE_WORD = 1'b0, BYTE_BYTE = 1'b1} byteWidthSel;
	typedef enum logic {RD_NONE = 1'b0, RD_ACTIVE = 1'b1} rdSel;
	typedef enum logic {WR_NONE = 1'b0, WR_ACTIVE = 1'b1} wrSel;

	typedef struct packed {
		aluOpSel aluOp;
		aluASrcSel aluASrc;
		aluBSrcSel aluBSrc;
		regAAddrSel regAAddr;
		regBAddrSel regBAddr;
		regSeqSel regSeq;
	} aluCtrl;

	typedef struct packed {
		addrBusSel addrBus;
		aluOpSel aluOp;
		aluASrcSel aluASrc;
		aluBSrcSel aluBSrc;
		byteWidthSel byteSel;
		dataBusSel dataBus;
		pcOffsetSel pcOffset;
		rdSel rd;
		regSeqSel regSeq;
		regAAddrSel regAAddr;
		regADinSel regADin;
		regBAddrSel regBAddr;
		wrSel wr;
	} ldsCtrl;

	typedef struct packed {
		addrBusSel addrBus;
		aluBSrcSel aluBSrc;
		pcBaseSel pcBase;
		pcOffsetSel pcOffset;
		rdSel rd;
		regSeqSel regSeq;
		regADinSel regADin;
		regAAddrSel regAAddr;
		regBAddrSel regBAddr;
	} jmpCtrl;

	typedef struct packed {
		aluOpSel aluOp;
		aluASrcSel aluASrc;
		aluBSrcSel aluBSrc;
		byteWidthSel byteSel;
		dataBusSel dataBus;
		rdSel rd;
		regAAddrSel regAAddr;
		regADinSel regADin;
		regSeqSel regSeq;
		regBAddrSel regBAddr;
		wrSel wr;
	} ctrlBundle;

	typedef struct packed {
		addrBusSel addrBus;
		pcBaseSel pcBase;
		pcOffsetSel pcOffset;
	} seqCtrl;

	localparam ctrlBundle CTRL_DEFAULT = '{
		aluOp: ALU_OP_MOV,
		aluASrc: ALUA_SRC_REG_A,
		aluBSrc: ALUB_SRC_REG_B,
		byteSel: BYTE_WORD,
		dataBus: DATA_BUS_REGA_DOUT,
		rd: RD_NONE,
		regAAddr: REGA_ADDR_ARGA,
		regADin: REGA_DIN_DIN,
		regSeq: REG_SEQ_NONE,
		regBAddr: REGB_ADDR_ARGB,
		wr: WR_NONE
	};

	// next address one word on from the pc.
	localparam seqCtrl SEQ_DEFAULT = '{
		addrBus: ADDR_BUS_PC_A,
		pcBase: PC_BASE_PC_A,
		pcOffset: PC_OFFSET_2
	};

endpackage

//--- hw/phaseSequencer.sv
`timescale 1ns/1ns

module phaseSequencer (
	input logic CLK,
	input logic RESET,
	input cpuDefs::instrWord wbDatIn,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [cpuDefs::ADDR_WIDTH-1:0] wbAdr,
	output cpuDefs::instrWord instr,
	output cpuDefs::instrGroup group,
	output logic fetch,
	output logic execute
);
	import cpuDefs::*;

	typedef enum logic {PH_FETCH, PH_EXECUTE} phaseState;

	phaseState phase;
	logic busActive;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= PH_FETCH;
			busActive <= 1'b0;
			wbAdr <= RESET_ADDR;
		end else begin
			case (phase)
				PH_FETCH: begin
					if (!busActive) begin
						busActive <= 1'b1; // first fetch after reset.
					end else if (wbAck) begin
						busActive <= 1'b0;
						phase <= PH_EXECUTE;
					end
				end
				PH_EXECUTE: begin
					// next fetch starts straight away.
					busActive <= 1'b1;
					wbAdr <= wbAdr + INSTR_STEP;
					phase <= PH_FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (phase == PH_FETCH && busActive && wbAck) begin
			instr <= wbDatIn;
		end
	end

	assign wbCyc = busActive;
	assign wbStb = busActive;
	assign wbWe = 1'b0; // read-only port.
	assign fetch = busActive;
	assign execute = (phase == PH_EXECUTE);
	assign group = groupOf(instr);

	assert property (@(posedge CLK) disable iff (RESET) wbStb |-> wbCyc);

	assert property (@(posedge CLK) disable iff (RESET) !(execute && fetch));

	// back-pressure holds the request.
	assert property (@(posedge CLK) disable iff (RESET)
		wbStb && !wbAck |=> wbStb && $stable(wbAdr));

endmodule

//--- hw/aluGroupDecoder.sv
`timescale 1ns/1ns

module aluGroupDecoder (
	input cpuDefs::instrWord instr,
	output ctrlDefs::aluCtrl ctrlOut
);
	import cpuDefs::*;
	import ctrlDefs::*;

	logic [3:0] opcode;

	assign opcode = opcodeOf(instr);

	always_comb begin
		ctrlOut.aluOp = aluOpSel'(opcode);
		ctrlOut.aluASrc = aluASrcSel'({1'b0, modeOf(instr)});
		ctrlOut.aluBSrc = aluBSrcSel'(flagsOf(instr));
		ctrlOut.regAAddr = regAAddrSel'(argAOf(instr));
		ctrlOut.regBAddr = regBAddrSel'(argBOf(instr));

		// compares and tests only set flags.
		if (opcode < ALU_WRITEBACK_LIMIT) begin
			ctrlOut.regSeq = REG_SEQ_WRITEBACK;
		end else begin
			ctrlOut.regSeq = REG_SEQ_NONE;
		end
	end

endmodule

//--- hw/ldsGroupDecoder.sv
`timescale 1ns/1ns

module ldsGroupDecoder (
	input cpuDefs::instrWord instr,
	output ctrlDefs::ldsCtrl ctrlOut
);
	import cpuDefs::*;
	import ctrlDefs::*;

	logic isStore;
	logic indexed;

	assign isStore = instr[LDS_STORE_BIT];
	assign indexed = (modeOf(instr) != 2'd0); // base plus offset through the alu.

	always_comb begin
		ctrlOut.rd = isStore ? RD_NONE : RD_ACTIVE;
		ctrlOut.wr = isStore ? WR_ACTIVE : WR_NONE;
		ctrlOut.byteSel = instr[LDS_BYTE_BIT] ? BYTE_BYTE : BYTE_WORD;

		if (indexed) begin
			ctrlOut.addrBus = ADDR_BUS_ALU_R;
			ctrlOut.aluOp = ALU_OP_ADD;
		end else begin
			ctrlOut.addrBus = ADDR_BUS_REGB_DOUT;
			ctrlOut.aluOp = ALU_OP_MOV;
		end

		ctrlOut.aluASrc = ALUA_SRC_REG_A;
		ctrlOut.aluBSrc = aluBSrcSel'(flagsOf(instr));
		ctrlOut.dataBus = DATA_BUS_REGA_DOUT;
		ctrlOut.pcOffset = PC_OFFSET_2;
		ctrlOut.regSeq = REG_SEQ_MEMORY;
		ctrlOut.regAAddr = regAAddrSel'(argAOf(instr));
		ctrlOut.regADin = REGA_DIN_DIN;
		ctrlOut.regBAddr = regBAddrSel'(argBOf(instr));
	end

	// memory port takes one direction per access.
	always_comb begin
		if (!$isunknown(instr)) begin
			assert (!(ctrlOut.rd == RD_ACTIVE && ctrlOut.wr == WR_ACTIVE));
		end
	end

endmodule

//--- hw/jmpGroupDecoder.sv
`timescale 1ns/1ns

module jmpGroupDecoder (
	input cpuDefs::instrWord instr,
	output ctrlDefs::jmpCtrl ctrlOut
);
	import cpuDefs::*;
	import ctrlDefs::*;

	logic indirect;
	logic isCall;

	assign indirect = instr[JMP_INDIRECT_BIT];
	assign isCall = instr[JMP_CALL_BIT];

	always_comb begin
		// indirect jumps read the target from memory.
		ctrlOut.addrBus = indirect ? ADDR_BUS_REGB_DOUT : ADDR_BUS_PC_A;
		ctrlOut.rd = indirect ? RD_ACTIVE : RD_NONE;

		ctrlOut.pcBase = pcBaseSel'(modeOf(instr));
		ctrlOut.pcOffset = pcOffsetSel'(instr[JMP_OFFSET_MSB:JMP_OFFSET_LSB]);
		ctrlOut.aluBSrc = aluBSrcSel'(flagsOf(instr));

		ctrlOut.regSeq = isCall ? REG_SEQ_LINK : REG_SEQ_NONE;
		ctrlOut.regADin = isCall ? REGA_DIN_ALU_R : REGA_DIN_DIN; // return address.

		ctrlOut.regAAddr = regAAddrSel'(argAOf(instr));
		ctrlOut.regBAddr = regBAddrSel'(argBOf(instr));
	end

endmodule

//--- hw/opxMultiplexer.sv
`timescale 1ns/1ns

module opxMultiplexer (
	input logic CLK,
	input logic RESET,
	input cpuDefs::instrGroup group,
	input logic fetch,
	input logic execute,
	input ctrlDefs::aluCtrl aluIn,
	input ctrlDefs::ldsCtrl ldsIn,
	input ctrlDefs::jmpCtrl jmpIn,
	output ctrlDefs::ctrlBundle ctrl,
	output ctrlDefs::seqCtrl seq
);
	import cpuDefs::*;
	import ctrlDefs::*;

	seqCtrl seqNext;

	always_comb begin
		ctrl = CTRL_DEFAULT;
		seqNext = SEQ_DEFAULT;

		case (group)
			GROUP_SYSTEM: begin
				// nothing decoded.
			end
			GROUP_LOAD_STORE: begin
				ctrl.aluOp = ldsIn.aluOp;
				ctrl.aluASrc = ldsIn.aluASrc;
				ctrl.aluBSrc = ldsIn.aluBSrc;
				ctrl.byteSel = ldsIn.byteSel;
				ctrl.dataBus = ldsIn.dataBus;
				ctrl.rd = ldsIn.rd;
				ctrl.regSeq = ldsIn.regSeq;
				ctrl.regAAddr = ldsIn.regAAddr;
				ctrl.regADin = ldsIn.regADin;
				ctrl.regBAddr = ldsIn.regBAddr;
				ctrl.wr = ldsIn.wr;
				seqNext.addrBus = ldsIn.addrBus;
				seqNext.pcOffset = ldsIn.pcOffset;
			end
			GROUP_JUMP: begin
				ctrl.aluOp = ALU_OP_MOV; // alu passes the target through.
				ctrl.aluBSrc = jmpIn.aluBSrc;
				ctrl.rd = jmpIn.rd;
				ctrl.regSeq = jmpIn.regSeq;
				ctrl.regAAddr = jmpIn.regAAddr;
				ctrl.regADin = jmpIn.regADin;
				ctrl.regBAddr = jmpIn.regBAddr;
				ctrl.wr = WR_NONE;
				seqNext.addrBus = jmpIn.addrBus;
				seqNext.pcBase = jmpIn.pcBase;
				seqNext.pcOffset = jmpIn.pcOffset;
			end
			GROUP_ARITHMETIC_LOGIC: begin
				ctrl.aluOp = aluIn.aluOp;
				ctrl.aluASrc = aluIn.aluASrc;
				ctrl.aluBSrc = aluIn.aluBSrc;
				ctrl.dataBus = DATA_BUS_ALU_R;
				ctrl.regSeq = aluIn.regSeq;
				ctrl.regAAddr = aluIn.regAAddr;
				ctrl.regADin = REGA_DIN_ALU_R;
				ctrl.regBAddr = aluIn.regBAddr;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			seq <= SEQ_DEFAULT;
		end else if (fetch) begin
			seq <= SEQ_DEFAULT; // fetch always steps the pc.
		end else if (execute) begin
			seq <= seqNext;
		end
	end

	// decoded selects last one fetch cycle only.
	assert property (@(posedge CLK) disable iff (RESET) fetch |=> seq == SEQ_DEFAULT);

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input logic CLK,
	input logic RESET,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [cpuDefs::ADDR_WIDTH-1:0] wbAdr,
	input cpuDefs::instrWord wbDatIn,
	input logic wbAck,
	output logic fetch,
	output logic execute,
	output ctrlDefs::ctrlBundle ctrl,
	output ctrlDefs::seqCtrl seq
);
	import cpuDefs::*;
	import ctrlDefs::*;

	instrWord instr;
	instrGroup group;
	aluCtrl aluSel;
	ldsCtrl ldsSel;
	jmpCtrl jmpSel;

	phaseSequencer i_phaseSequencer (
		.CLK(CLK),
		.RESET(RESET),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.instr(instr),
		.group(group),
		.fetch(fetch),
		.execute(execute)
	);

	// all three decode every word and the group picks one.
	aluGroupDecoder i_aluGroupDecoder (.instr(instr), .ctrlOut(aluSel));
	ldsGroupDecoder i_ldsGroupDecoder (.instr(instr), .ctrlOut(ldsSel));
	jmpGroupDecoder i_jmpGroupDecoder (.instr(instr), .ctrlOut(jmpSel));

	opxMultiplexer i_opxMultiplexer (
		.CLK(CLK),
		.RESET(RESET),
		.group(group),
		.fetch(fetch),
		.execute(execute),
		.aluIn(aluSel),
		.ldsIn(ldsSel),
		.jmpIn(jmpSel),
		.ctrl(ctrl),
		.seq(seq)
	);

endmodule

//--- test/tbControlUnit.sv
`timescale 1ns/1ns

module tbControlUnit;
	import cpuDefs::*;
	import ctrlDefs::*;

	localparam int TOTAL_INSTR = 108; // 8 + 20 + 8 + 8 + 64.
	localparam int CYCLE_LIMIT = TOTAL_INSTR * 6 + 50;

	logic CLK;
	logic RESET;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [ADDR_WIDTH-1:0] wbAdr;
	instrWord wbDatIn = '0;
	logic wbAck = 1'b0;
	logic fetch;
	logic execute;
	ctrlBundle ctrl;
	seqCtrl seq;

	instrWord instrMem [0:255];
	logic [1:0] waitMem [0:255]; // wait states per word.
	logic inCycle = 1'b0;
	logic [1:0] waitLeft = 2'd0;
	integer seed = 32'ha6a1_012b;
	int cycleCount = 0;

	controlUnit i_controlUnit (
		.CLK(CLK),
		.RESET(RESET),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.fetch(fetch),
		.execute(execute),
		.ctrl(ctrl),
		.seq(seq)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// wishbone memory answering on the falling edge.
	always @(negedge CLK) begin
		if (wbCyc && wbStb) begin
			if (!inCycle) begin
				inCycle = 1'b1;
				waitLeft = waitMem[wbAdr[8:1]];
			end
			if (waitLeft == 2'd0) begin
				wbAck = 1'b1;
				wbDatIn = instrMem[wbAdr[8:1]];
			end else begin
				waitLeft = waitLeft - 2'd1;
				wbAck = 1'b0;
			end
		end else begin
			inCycle = 1'b0;
			wbAck = 1'b0;
		end
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR %s got %h expected %h", name, got, expected);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] nextRandom();
		return 16'($random(seed));
	endfunction

	function automatic instrWord makeInstr(input logic [1:0] grp, input logic [3:0] op,
			input logic [1:0] a, input logic [2:0] b, input logic [1:0] m, input logic [2:0] f);
		return {grp, op, a, b, m, f};
	endfunction

	function automatic seqCtrl defaultSeq();
		seqCtrl s;
		s.addrBus = ADDR_BUS_PC_A;
		s.pcBase = PC_BASE_PC_A;
		s.pcOffset = PC_OFFSET_2;
		return s;
	endfunction

	// reference decode straight from the field layout.
	function automatic ctrlBundle expectedCtrl(input instrWord w);
		ctrlBundle c;
		c.aluOp = ALU_OP_MOV;
		c.aluASrc = ALUA_SRC_REG_A;
		c.aluBSrc = ALUB_SRC_REG_B;
		c.byteSel = BYTE_WORD;
		c.dataBus = DATA_BUS_REGA_DOUT;
		c.rd = RD_NONE;
		c.regAAddr = REGA_ADDR_ARGA;
		c.regADin = REGA_DIN_DIN;
		c.regSeq = REG_SEQ_NONE;
		c.regBAddr = REGB_ADDR_ARGB;
		c.wr = WR_NONE;
		case (w[15:14])
			2'd1: begin
				c.rd = rdSel'(!w[13]);
				c.wr = wrSel'(w[13]);
				c.byteSel = byteWidthSel'(w[12]);
				c.aluOp = (w[4:3] != 2'd0) ? ALU_OP_ADD : ALU_OP_MOV;
				c.aluBSrc = aluBSrcSel'(w[2:0]);
				c.regSeq = REG_SEQ_MEMORY;
				c.regAAddr = regAAddrSel'(w[9:8]);
				c.regBAddr = regBAddrSel'(w[7:5]);
			end
			2'd2: begin
				c.aluBSrc = aluBSrcSel'(w[2:0]);
				c.rd = rdSel'(w[13]);
				c.regSeq = w[10] ? REG_SEQ_LINK : REG_SEQ_NONE;
				c.regADin = w[10] ? REGA_DIN_ALU_R : REGA_DIN_DIN;
				c.regAAddr = regAAddrSel'(w[9:8]);
				c.regBAddr = regBAddrSel'(w[7:5]);
			end
			2'd3: begin
				c.aluOp = aluOpSel'(w[13:10]);
				c.aluASrc = aluASrcSel'({1'b0, w[4:3]});
				c.aluBSrc = aluBSrcSel'(w[2:0]);
				c.dataBus = DATA_BUS_ALU_R;
				c.regSeq = (w[13:10] < 4'd8) ? REG_SEQ_WRITEBACK : REG_SEQ_NONE;
				c.regAAddr = regAAddrSel'(w[9:8]);
				c.regADin = REGA_DIN_ALU_R;
				c.regBAddr = regBAddrSel'(w[7:5]);
			end
			default: begin
			end
		endcase
		return c;
	endfunction

	function automatic seqCtrl expectedSeq(input instrWord w);
		seqCtrl s;
		s = defaultSeq();
		if (w[15:14] == 2'd1) begin
			s.addrBus = (w[4:3] != 2'd0) ? ADDR_BUS_ALU_R : ADDR_BUS_REGB_DOUT;
		end else if (w[15:14] == 2'd2) begin
			s.addrBus = w[13] ? ADDR_BUS_REGB_DOUT : ADDR_BUS_PC_A;
			s.pcBase = pcBaseSel'(w[4:3]);
			s.pcOffset = pcOffsetSel'(w[12:11]);
		end
		return s;
	endfunction

	task automatic applyReset();
		@(negedge CLK);
		RESET = 1'b1;
		repeat (2) @(negedge CLK);
		RESET = 1'b0;
		checkValue("wbCyc", 32'(wbCyc), 32'd0);
		checkValue("wbStb", 32'(wbStb), 32'd0);
		checkValue("execute", 32'(execute), 32'd0);
		checkValue("seq", 32'(seq), 32'(defaultSeq()));
	endtask

	// one instruction from its first fetch cycle to the cycle after execute.
	task automatic runInstruction(input int idx);
		instrWord word;
		int fetchCycles;
		word = instrMem[8'(idx)];
		fetchCycles = 0;
		while (!wbCyc) begin
			@(negedge CLK);
		end
		while (!execute) begin
			checkValue("wbCyc", 32'(wbCyc), 32'd1);
			checkValue("wbStb", 32'(wbStb), 32'd1);
			checkValue("wbWe", 32'(wbWe), 32'd0);
			checkValue("fetch", 32'(fetch), 32'd1);
			checkValue("wbAdr", 32'(wbAdr), 32'(idx * 2));
			if (fetchCycles > 0) begin
				checkValue("seq", 32'(seq), 32'(defaultSeq()));
			end
			fetchCycles = fetchCycles + 1;
			@(negedge CLK);
		end
		checkValue("fetchCycles", 32'(fetchCycles), 32'(waitMem[8'(idx)]) + 32'd1);
		checkValue("fetch", 32'(fetch), 32'd0);
		checkValue("wbCyc", 32'(wbCyc), 32'd0);
		checkValue("ctrl", 32'(ctrl), 32'(expectedCtrl(word)));
		checkValue("seq", 32'(seq), 32'(defaultSeq()));
		@(negedge CLK);
		checkValue("execute", 32'(execute), 32'd0);
		checkValue("fetch", 32'(fetch), 32'd1);
		checkValue("wbAdr", 32'(wbAdr), 32'((idx + 1) * 2));
		checkValue("seq", 32'(seq), 32'(expectedSeq(word)));
	endtask

	task automatic runProgram(input int count);
		for (int i = 0; i < count; i++) begin
			runInstruction(i);
		end
	endtask

	task automatic testFetchProtocol();
		logic [15:0] r;
		applyReset();
		for (int i = 0; i < 8; i++) begin
			r = nextRandom();
			instrMem[8'(i)] = {2'd0, r[13:0]};
			r = nextRandom();
			waitMem[8'(i)] = r[1:0];
		end
		runProgram(8);
	endtask

	task automatic testAluSystem();
		logic [15:0] r;
		applyReset();
		for (int i = 0; i < 20; i++) begin
			r = nextRandom();
			if (i < 16) begin
				instrMem[8'(i)] = makeInstr(2'd3, 4'(i), r[1:0], r[4:2], r[6:5], r[9:7]);
			end else begin
				instrMem[8'(i)] = {2'd0, r[13:0]};
			end
			waitMem[8'(i)] = r[15:14];
		end
		runProgram(20);
	endtask

	task automatic testLoadStore();
		logic [15:0] r;
		logic [1:0] mode;
		applyReset();
		for (int i = 0; i < 8; i++) begin
			r = nextRandom();
			mode = 2'd0;
			if (i[2]) begin
				mode = (r[1:0] == 2'd0) ? 2'd1 : r[1:0]; // indexed.
			end
			instrMem[8'(i)] = makeInstr(2'd1, {i[0], i[1], r[3:2]}, r[5:4], r[8:6], mode,
				r[11:9]);
			waitMem[8'(i)] = r[13:12];
		end
		runProgram(8);
	endtask

	task automatic testJumpCall();
		logic [15:0] r;
		applyReset();
		for (int i = 0; i < 8; i++) begin
			r = nextRandom();
			instrMem[8'(i)] = makeInstr(2'd2, {i[0], r[1:0], i[1]}, r[3:2], r[6:4], r[8:7],
				r[11:9]);
			waitMem[8'(i)] = 2'd1; // fetch spans two cycles.
		end
		waitMem[8] = 2'd1; // fetch after the last jump also spans two cycles.
		runProgram(8);
		@(negedge CLK);
		checkValue("fetch", 32'(fetch), 32'd1);
		checkValue("seq", 32'(seq), 32'(defaultSeq()));
	endtask

	task automatic testRandomProgram();
		logic [15:0] r;
		applyReset();
		for (int i = 0; i < 64; i++) begin
			instrMem[8'(i)] = nextRandom();
			r = nextRandom();
			waitMem[8'(i)] = r[1:0];
		end
		runProgram(64);
	endtask

	initial begin
		RESET = 1'b1;
		for (int i = 0; i < 256; i++) begin
			instrMem[8'(i)] = 16'h2a00 ^ 16'(i);
			waitMem[8'(i)] = 2'(i % 3);
		end
		testFetchProtocol();
		testAluSystem();
		testLoadStore();
		testJumpCall();
		testRandomProgram();
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- files.f
hw/cpuDefs.sv
hw/ctrlDefs.sv
hw/phaseSequencer.sv
hw/aluGroupDecoder.sv
hw/ldsGroupDecoder.sv
hw/jmpGroupDecoder.sv
hw/opxMultiplexer.sv
hw/controlUnit.sv
test/tbControlUnit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tbControlUnit -o simControlUnit
./obj_dir/simControlUnit > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation FAILED: run ended early"
	exit 1
fi
echo "simulation passed"
